//--- verilog/washer_pkg.sv
package washer_pkg;

	////////////////////////////////////////////////////////////////////////////
	// phases and programs
	////////////////////////////////////////////////////////////////////////////

	// dry-only reuses the tail of the wash sequence from spin on
	typedef enum logic [3:0] {
		idle,
		fill,
		wash,
		drain,
		fill2,
		rinse,
		drain2,
		spin,
		drain3,
		rev_spin,
		drain4,
		fault_hold,
		done
	} phase_e;

	typedef enum logic [1:0] {
		prog_heavy,
		prog_normal,
		prog_light,
		prog_dry
	} program_e;

	////////////////////////////////////////////////////////////////////////////
	// seconds and phase durations
	////////////////////////////////////////////////////////////////////////////

	localparam int SECS_W = 8;

	typedef logic [SECS_W-1:0] secs_t;

	localparam secs_t FILL_SECS     = 8'd3;
	// rinse runs as long as wash
	localparam secs_t WASH_SECS     = 8'd4;
	localparam secs_t DRAIN_SECS    = 8'd2;
	localparam secs_t SPIN_SECS     = 8'd4;
	localparam secs_t REV_SPIN_SECS = 8'd5;
	localparam secs_t DONE_SECS     = 8'd2;

	////////////////////////////////////////////////////////////////////////////
	// block to block bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic     valid;
		program_e prog;
	} start_req_t;

	typedef struct packed {
		logic  load;
		secs_t secs;
	} timer_cmd_t;

	// phase lamps msb first, then the program level bar
	typedef struct packed {
		logic       lamp_fill;
		logic       lamp_wash;
		logic       lamp_drain;
		logic       lamp_spin;
		logic       lamp_rev;
		logic [2:0] level;
	} lamps_t;

endpackage

//--- verilog/panel_input.sv
`timescale 1ns/1ns

module panel_input (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_start_n,
	input  logic [3:0]             i_mode,
	input  logic                   i_fault,
	output washer_pkg::start_req_t o_start,
	output logic                   o_fault
);

	import washer_pkg::*;

	logic [1:0] start_sync;
	logic       start_prev;
	logic [1:0] fault_sync;
	logic       press;
	logic       mode_ok;
	program_e   mode_prog;

	// one-hot mode switch, anything else is not a program
	always_comb begin
		mode_ok   = 1'b1;
		mode_prog = prog_heavy;
		case (i_mode)
			4'b0001: mode_prog = prog_heavy;
			4'b0010: mode_prog = prog_normal;
			4'b0100: mode_prog = prog_light;
			4'b1000: mode_prog = prog_dry;
			default: mode_ok = 1'b0;
		endcase
	end

	// button is active low, so a press is a falling edge
	assign press = start_prev & ~start_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_sync <= 2'b11;
			start_prev <= 1'b1;
			fault_sync <= 2'b00;
			o_start    <= '0;
		end else begin
			start_sync    <= {start_sync[0], i_start_n};
			start_prev    <= start_sync[1];
			fault_sync    <= {fault_sync[0], i_fault};
			o_start.valid <= press & mode_ok;
			o_start.prog  <= mode_prog;
		end
	end

	assign o_fault = fault_sync[1];

endmodule

//--- verilog/cycle_sequencer.sv
`timescale 1ns/1ns

module cycle_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  washer_pkg::start_req_t i_start,
	input  logic                   i_fault,
	input  logic                   i_expire,
	output washer_pkg::timer_cmd_t o_timer,
	output washer_pkg::phase_e     o_phase,
	output washer_pkg::program_e   o_program
);

	import washer_pkg::*;

	phase_e     phase_q;
	phase_e     phase_d;
	program_e   program_q;
	timer_cmd_t timer_q;

	////////////////////////////////////////////////////////////////////////////
	// phase order and durations
	////////////////////////////////////////////////////////////////////////////

	function automatic phase_e next_phase(input phase_e cur, input logic fault);
		case (cur)
			fill:     next_phase = wash;
			wash:     next_phase = drain;
			drain:    next_phase = fill2;
			fill2:    next_phase = rinse;
			rinse:    next_phase = drain2;
			// spin is where a fault parks the machine
			drain2:   next_phase = fault ? fault_hold : spin;
			spin:     next_phase = drain3;
			drain3:   next_phase = rev_spin;
			rev_spin: next_phase = drain4;
			drain4:   next_phase = done;
			default:  next_phase = idle;
		endcase
	endfunction

	// zero for the untimed phases
	function automatic secs_t phase_secs(input phase_e p);
		case (p)
			fill, fill2:                    phase_secs = FILL_SECS;
			wash, rinse:                    phase_secs = WASH_SECS;
			drain, drain2, drain3, drain4:  phase_secs = DRAIN_SECS;
			spin:                           phase_secs = SPIN_SECS;
			rev_spin:                       phase_secs = REV_SPIN_SECS;
			done:                           phase_secs = DONE_SECS;
			default:                        phase_secs = '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// phase FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		phase_d = phase_q;
		case (phase_q)
			idle: begin
				if (i_start.valid) begin
					phase_d = (i_start.prog == prog_dry) ? spin : fill;
				end
			end
			// resume past the skipped spin
			fault_hold: begin
				if (!i_fault) begin
					phase_d = drain3;
				end
			end
			default: begin
				if (i_expire) begin
					phase_d = next_phase(phase_q, i_fault);
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q   <= idle;
			program_q <= prog_heavy;
			timer_q   <= '0;
		end else begin
			phase_q <= phase_d;
			if (phase_q == idle && i_start.valid) begin
				program_q <= i_start.prog;
			end
			// timer is loaded alongside every step into a timed phase
			timer_q.load <= (phase_d != phase_q) && (phase_secs(phase_d) != '0);
			timer_q.secs <= phase_secs(phase_d);
		end
	end

	assign o_timer   = timer_q;
	assign o_phase   = phase_q;
	assign o_program = program_q;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// untimed phases must leave the timer alone
	a_no_load_untimed: assert property (
		@(posedge clk) disable iff (!rst_n)
		timer_q.load |-> !(phase_q inside {idle, fault_hold})
	);

	// an idle machine has nothing counting down
	a_no_expire_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_expire |-> phase_q != idle
	);

endmodule

//--- verilog/phase_timer.sv
`timescale 1ns/1ns

module phase_timer #(
	parameter int CLKS_PER_SEC = 50_000_000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  washer_pkg::timer_cmd_t i_cmd,
	output logic                   o_expire,
	output washer_pkg::secs_t      o_remaining
);

	import washer_pkg::*;

	localparam int PRESC_W = ($clog2(CLKS_PER_SEC) > 0) ? $clog2(CLKS_PER_SEC) : 1;
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(CLKS_PER_SEC - 1);

	logic [PRESC_W-1:0] presc_q;
	logic [PRESC_W-1:0] presc_cur;
	secs_t              count_q;
	secs_t              count_cur;
	logic               running;
	logic               tick;

	// load cycle already counts as the first clock of the first second
	assign count_cur = i_cmd.load ? i_cmd.secs : count_q;
	assign presc_cur = i_cmd.load ? '0 : presc_q;

	assign running     = (count_cur != '0);
	assign tick        = running && (presc_cur == PRESC_LAST);
	assign o_expire    = tick && (count_cur == secs_t'(1));
	assign o_remaining = count_cur;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc_q <= '0;
			count_q <= '0;
		end else begin
			if (!running || tick) begin
				presc_q <= '0;
			end else begin
				presc_q <= presc_cur + 1'b1;
			end
			count_q <= tick ? count_cur - 1'b1 : count_cur;
		end
	end

	if (CLKS_PER_SEC < 2) begin : g_rate_check
		$error("phase_timer: CLKS_PER_SEC must be at least 2");
	end

	// last second ends on a count of one
	a_expire_from_one: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_expire |-> $past(count_cur) == secs_t'(1)
	);

endmodule

//--- verilog/panel_display.sv
`timescale 1ns/1ns

module panel_display (
	input  logic                 clk,
	input  logic                 rst_n,
	input  washer_pkg::phase_e   i_phase,
	input  washer_pkg::program_e i_program,
	input  washer_pkg::secs_t    i_remaining,
	output washer_pkg::lamps_t   o_lamps,
	output logic                 o_done,
	output washer_pkg::secs_t    o_remaining
);

	import washer_pkg::*;

	logic [2:0] level;
	lamps_t     lamps_d;

	// level bar, longer for heavier loads
	always_comb begin
		case (i_program)
			prog_heavy:  level = 3'b111;
			prog_normal: level = 3'b011;
			prog_light:  level = 3'b001;
			default:     level = 3'b000;
		endcase
	end

	always_comb begin
		lamps_d       = '0;
		lamps_d.level = level;
		case (i_phase)
			fill, fill2:                   lamps_d.lamp_fill  = 1'b1;
			wash, rinse:                   lamps_d.lamp_wash  = 1'b1;
			drain, drain2, drain3, drain4: lamps_d.lamp_drain = 1'b1;
			// held machine keeps the spin lamp on
			spin, fault_hold:              lamps_d.lamp_spin  = 1'b1;
			rev_spin:                      lamps_d.lamp_rev   = 1'b1;
			done: begin
				lamps_d = {5'b11111, level};
			end
			default: lamps_d = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_lamps     <= '0;
			o_done      <= 1'b0;
			o_remaining <= '0;
		end else begin
			o_lamps     <= lamps_d;
			o_done      <= (i_phase == done);
			o_remaining <= i_remaining;
		end
	end

endmodule

//--- verilog/washer_top.sv
`timescale 1ns/1ns

module washer_top #(
	parameter int CLKS_PER_SEC = 50_000_000
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_start_n,
	input  logic [3:0]         i_mode,
	input  logic               i_fault,
	output washer_pkg::lamps_t o_lamps,
	output logic               o_done,
	output washer_pkg::secs_t  o_remaining
);

	import washer_pkg::*;

	start_req_t start_req;
	logic       fault_sync;
	timer_cmd_t timer_cmd;
	logic       expire;
	secs_t      timer_secs;
	phase_e     phase;
	program_e   prog;

	panel_input u_input (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_start_n(i_start_n),
		.i_mode   (i_mode),
		.i_fault  (i_fault),
		.o_start  (start_req),
		.o_fault  (fault_sync)
	);

	cycle_sequencer u_sequencer (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_start  (start_req),
		.i_fault  (fault_sync),
		.i_expire (expire),
		.o_timer  (timer_cmd),
		.o_phase  (phase),
		.o_program(prog)
	);

	phase_timer #(
		.CLKS_PER_SEC(CLKS_PER_SEC)
	) u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_cmd      (timer_cmd),
		.o_expire   (expire),
		.o_remaining(timer_secs)
	);

	panel_display u_display (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_phase    (phase),
		.i_program  (prog),
		.i_remaining(timer_secs),
		.o_lamps    (o_lamps),
		.o_done     (o_done),
		.o_remaining(o_remaining)
	);

endmodule

//--- verification/washer_tb.sv
`timescale 1ns/1ns

module washer_tb;

	import washer_pkg::*;

	localparam int CLKS_PER_SEC  = 4;
	localparam int CLK_PERIOD    = 40;
	localparam int GOLDEN_WORDS  = 128;
	// dark panel watch after a rejected press, well past the start latency
	localparam int IGNORE_CYCLES = 16;

	logic        clk;
	logic        rst_n;
	logic        i_start_n;
	logic [3:0]  i_mode;
	logic        i_fault;
	lamps_t      o_lamps;
	logic        o_done;
	secs_t       o_remaining;

	logic [15:0] golden_mem [0:GOLDEN_WORDS-1];
	logic [31:0] lfsr_state;
	int          limit_cycles;

	washer_top #(
		.CLKS_PER_SEC(CLKS_PER_SEC)
	) dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_start_n  (i_start_n),
		.i_mode     (i_mode),
		.i_fault    (i_fault),
		.o_lamps    (o_lamps),
		.o_done     (o_done),
		.o_remaining(o_remaining)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// random gaps and press widths
	////////////////////////////////////////////////////////////////////////////

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_lamps(input lamps_t exp, input lamps_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0t ns: o_lamps expected %h, actual %h",
				$time, exp, act));
		end
	endtask

	task automatic check_secs(input secs_t exp, input secs_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0t ns: o_remaining expected %0d, actual %0d",
				$time, exp, act));
		end
	endtask

	task automatic check_done(input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("Error at %0t ns: o_done expected %b, actual %b",
				$time, exp, act));
		end
	endtask

	task automatic check_cycles(input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("Error at %0t ns: o_lamps phase cycles expected %0d, actual %0d",
				$time, exp, act));
		end
	endtask

	// done word lights every phase lamp
	function automatic logic shows_done(input lamps_t w);
		shows_done = w.lamp_fill & w.lamp_wash & w.lamp_drain & w.lamp_spin & w.lamp_rev;
	endfunction

	// watchdog budget from the golden timings, gaps and presses per test on top
	function automatic int run_budget();
		int cycles;
		int i;
		cycles = 200;
		for (i = 0; i < GOLDEN_WORDS; i++) begin
			case (golden_mem[i][15:12])
				4'h1:    cycles += int'(golden_mem[i][3:0]) + 64;
				4'h2:    cycles += int'(golden_mem[i][3:0]) * CLKS_PER_SEC;
				default: ;
			endcase
		end
		return cycles;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus and sequence tracking
	////////////////////////////////////////////////////////////////////////////

	task automatic press_start(input logic [3:0] mode);
		int width;
		take_bits(3, width);
		width = width + 1;
		@(posedge clk);
		i_mode    <= mode;
		i_start_n <= 1'b0;
		fork
			begin
				repeat (width) @(posedge clk);
				i_start_n <= 1'b1;
			end
		join_none
	endtask

	// counts sampling edges until the lamp word moves
	task automatic wait_lamps_change(input lamps_t shown, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (o_lamps === shown) begin
				check_done(shows_done(shown), o_done);
			end
		end while (o_lamps === shown);
	endtask

	task automatic hold_until_release(input lamps_t shown, input int delay);
		repeat (delay) begin
			@(negedge clk);
			check_lamps(shown, o_lamps);
			check_secs('0, o_remaining);
			check_done(1'b0, o_done);
		end
		@(posedge clk);
		i_fault <= 1'b0;
	endtask

	task automatic run_test(inout int idx);
		logic [15:0] word;
		logic [3:0]  mode;
		lamps_t      shown;
		lamps_t      exp_lamps;
		secs_t       exp_secs;
		int          release_delay;
		int          gap;
		int          cycles;
		int          expect_cycles;
		int          words;

		word          = golden_mem[idx];
		idx++;
		mode          = word[11:8];
		release_delay = int'(word[3:0]);
		take_bits(4, gap);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		i_fault <= word[4];
		press_start(mode);

		shown = '0;
		// press to first lamp change, counted to the sampling edge
		expect_cycles = 6;
		words = 0;
		while (golden_mem[idx][15:12] == 4'h2) begin
			exp_lamps = golden_mem[idx][11:4];
			exp_secs  = secs_t'(golden_mem[idx][3:0]);
			idx++;
			wait_lamps_change(shown, cycles);
			check_lamps(exp_lamps, o_lamps);
			check_secs(exp_secs, o_remaining);
			check_done(shows_done(exp_lamps), o_done);
			check_cycles(expect_cycles, cycles);
			shown = exp_lamps;
			words++;
			// a second press mid-run must change nothing
			if (words == 3) begin
				press_start((mode == 4'b0001) ? 4'b1000 : 4'b0001);
			end
			if (exp_secs == '0) begin
				hold_until_release(shown, release_delay);
				// two sync flops, the FSM step and the panel register
				expect_cycles = 5;
			end else begin
				expect_cycles = int'(exp_secs) * CLKS_PER_SEC;
			end
		end
		if (golden_mem[idx] !== 16'hf000) begin
			abort_run("golden file has a test that is not closed by f000");
		end
		idx++;

		if (words == 0) begin
			repeat (IGNORE_CYCLES) begin
				@(negedge clk);
				check_lamps('0, o_lamps);
				check_secs('0, o_remaining);
				check_done(1'b0, o_done);
			end
		end else begin
			// panel dark again once done runs out
			wait_lamps_change(shown, cycles);
			check_lamps('0, o_lamps);
			check_secs('0, o_remaining);
			check_done(1'b0, o_done);
			check_cycles(expect_cycles, cycles);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main flow and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * CLK_PERIOD);
		abort_run($sformatf("timeout after %0d cycles, the controller stalled", limit_cycles));
	end

	initial begin
		int idx;
		clk        = 1'b0;
		rst_n      = 1'b0;
		i_start_n  = 1'b1;
		i_mode     = 4'b0000;
		i_fault    = 1'b0;
		lfsr_state = 32'ha7bf;
		$readmemh("verification/washer_golden.txt", golden_mem);
		if ($isunknown(golden_mem[0])) begin
			abort_run("golden file verification/washer_golden.txt is missing or empty");
		end
		limit_cycles = run_budget();

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_lamps('0, o_lamps);
		check_done(1'b0, o_done);
		check_secs('0, o_remaining);

		idx = 0;
		while (golden_mem[idx][15:12] == 4'h1) begin
			run_test(idx);
		end
		if (golden_mem[idx] !== 16'h0000) begin
			abort_run("golden file holds a record that is neither a test nor the end marker");
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- verification/washer_golden.txt
// 1MFD test header: one-hot mode M, fault flag F, fault release delay D in cycles
// 2LLS lamp word LL and o_remaining S at each change (S 0 = fault hold), f000 ends a test
1000
f000
1100
2873 2474 2272 2873 2474 2272
2174 2272 20f5 2272 2ff2
f000
1200
2833 2434 2232 2833 2434 2232
2134 2232 20b5 2232 2fb2
f000
1300
f000
1400
2813 2414 2212 2813 2414 2212
2114 2212 2095 2212 2f92
f000
1800
2104 2202 2085 2202 2f82
f000
1216
2833 2434 2232 2833 2434 2232
2130 2232 20b5 2232 2fb2
f000
0000

//--- compile.f
verilog/washer_pkg.sv
verilog/panel_input.sv
verilog/cycle_sequencer.sv
verilog/phase_timer.sv
verilog/panel_display.sv
verilog/washer_top.sv
verification/washer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= washer_tb
RTL_TOP   ?= washer_top
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
